//--- flist.f
rtl/la32_pkg.sv
rtl/la32_decode.sv
rtl/la32_regfile.sv
rtl/la32_alu.sv
rtl/la32_core.sv
testbench/la32_core_tb.sv

//--- Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module la32_core_tb \
		-f flist.f -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vla32_core_tb

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/la32_core_tb.sv
`timescale 1ns/1ps

module la32_core_tb;

    localparam logic [31:0] reset_pc = 32'h1c000000;
    localparam int run_cycles     = 2000;
    localparam int timeout_cycles = 2100;

    typedef enum int {
        k_add_w, k_sub_w, k_slt, k_sltu, k_nor, k_and, k_or, k_xor, k_slli_w, k_srli_w,
        k_srai_w, k_addi_w, k_ld_w, k_st_w, k_jirl, k_b, k_bl, k_beq, k_bne, k_lu12i_w
    } kind_t;

    logic        clk;
    logic        reset;
    logic        inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    kind_t       kind_mem [256];

    // Instruction-set model state.
    logic [31:0] model_pc;
    logic [31:0] model_regs [8];
    logic [31:0] model_dmem [256];

    logic [31:0] lfsr_state = 32'd60;
    int          cycle_count = 0;

    la32_core #(
        .reset_pc (reset_pc)
    ) i_la32_core (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // ####################
    // Clock, memories, timeout

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign inst_sram_rdata = imem[inst_sram_addr[9:2]];
    assign data_sram_rdata = dmem[data_sram_addr[9:2]];

    always @(posedge clk) begin
        if (data_sram_we) begin
            dmem[data_sram_addr[9:2]] = data_sram_wdata;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Run did not finish within %0d cycles", timeout_cycles);
            $display("Finished with errors");
            $fatal(1, "Timeout");
        end
    end

    // ####################
    // Helpers

    // Galois LFSR stepped once per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int i;
        r = 32'd0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return r;
    endfunction

    function automatic logic [31:0] read_reg(input logic [4:0] idx);
        return (idx == 5'd0) ? 32'd0 : model_regs[idx[2:0]];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL time %0t %s got %h expected %h", $time, name, got, expected);
            $display("Finished with errors");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_idle();
        check_value("data_sram_we", {31'd0, data_sram_we}, 32'd0);
        check_value("debug_wb_rf_we", {28'd0, debug_wb_rf_we}, 32'd0);
    endtask

    // Seven addi.w set r1..r7 before random code over r0..r7.
    task automatic build_program();
        la32_pkg::la32_inst_t w;
        kind_t       kind;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [4:0]  shamt;
        logic [11:0] si12;
        logic [15:0] offs16;
        logic [25:0] offs26;
        logic [19:0] si20;
        int i;
        for (i = 0; i < 256; i++) begin
            dmem[i] = rand_bits(32);
            model_dmem[i] = dmem[i];
        end
        for (i = 0; i < 256; i++) begin
            kind   = kind_t'(rand_bits(5) % 32'd20);
            rd     = 5'(rand_bits(3));
            rj     = 5'(rand_bits(3));
            rk     = 5'(rand_bits(3));
            shamt  = 5'(rand_bits(5));
            si12   = 12'(rand_bits(12));
            // Low byte keeps the target index moving forward.
            offs16 = 16'(rand_bits(16));
            offs16[7:0] = 8'(rand_bits(4)) + 8'd1;
            offs26 = 26'(rand_bits(26));
            offs26[7:0] = 8'(rand_bits(4)) + 8'd1;
            si20   = 20'(rand_bits(20));
            if (i < 7) begin
                kind = k_addi_w;
                rd   = 5'(i + 1);
                rj   = 5'd0;
            end
            case (kind)
                k_add_w:  w.fmt_3r = {la32_pkg::op_add_w, rk, rj, rd};
                k_sub_w:  w.fmt_3r = {la32_pkg::op_sub_w, rk, rj, rd};
                k_slt:    w.fmt_3r = {la32_pkg::op_slt, rk, rj, rd};
                k_sltu:   w.fmt_3r = {la32_pkg::op_sltu, rk, rj, rd};
                k_nor:    w.fmt_3r = {la32_pkg::op_nor, rk, rj, rd};
                k_and:    w.fmt_3r = {la32_pkg::op_and, rk, rj, rd};
                k_or:     w.fmt_3r = {la32_pkg::op_or, rk, rj, rd};
                k_xor:    w.fmt_3r = {la32_pkg::op_xor, rk, rj, rd};
                k_slli_w: w.fmt_3r = {la32_pkg::op_slli_w, shamt, rj, rd};
                k_srli_w: w.fmt_3r = {la32_pkg::op_srli_w, shamt, rj, rd};
                k_srai_w: w.fmt_3r = {la32_pkg::op_srai_w, shamt, rj, rd};
                k_addi_w: w.fmt_2ri12 = {la32_pkg::op_addi_w, si12, rj, rd};
                k_ld_w:   w.fmt_2ri12 = {la32_pkg::op_ld_w, si12, rj, rd};
                k_st_w:   w.fmt_2ri12 = {la32_pkg::op_st_w, si12, rj, rd};
                k_jirl:   w.fmt_2ri16 = {la32_pkg::op_jirl, offs16, rj, rd};
                k_beq:    w.fmt_2ri16 = {la32_pkg::op_beq, offs16, rj, rd};
                k_bne:    w.fmt_2ri16 = {la32_pkg::op_bne, offs16, rj, rd};
                k_b:      w.fmt_i26 = {la32_pkg::op_b, offs26[15:0], offs26[25:16]};
                k_bl:     w.fmt_i26 = {la32_pkg::op_bl, offs26[15:0], offs26[25:16]};
                default:  w.fmt_1ri20 = {la32_pkg::op_lu12i_w, si20, rd};
            endcase
            imem[i] = w;
            kind_mem[i] = kind;
        end
    endtask

    // Executes one instruction in the model and compares the trace.
    task automatic commit_and_check();
        la32_pkg::la32_inst_t w;
        kind_t       kind;
        logic [31:0] rj_val;
        logic [31:0] rk_val;
        logic [31:0] rd_val;
        logic [31:0] si12x;
        logic [31:0] offs16x;
        logic [31:0] offs26x;
        logic [31:0] addr;
        logic [31:0] result;
        logic [31:0] next_pc;
        logic [4:0]  dest;
        logic        reg_we;
        w       = imem[model_pc[9:2]];
        kind    = kind_mem[model_pc[9:2]];
        rj_val  = read_reg(w.fmt_3r.rj);
        rk_val  = read_reg(w.fmt_3r.rk);
        rd_val  = read_reg(w.fmt_3r.rd);
        si12x   = {{20{w.fmt_2ri12.si12[11]}}, w.fmt_2ri12.si12};
        offs16x = {{14{w.fmt_2ri16.offs16[15]}}, w.fmt_2ri16.offs16, 2'b0};
        offs26x = {{4{w.fmt_i26.offs_hi[9]}}, w.fmt_i26.offs_hi, w.fmt_i26.offs_lo, 2'b0};
        addr    = rj_val + si12x;
        result  = 32'd0;
        next_pc = model_pc + 32'd4;
        dest    = w.fmt_3r.rd;
        reg_we  = 1'b1;
        case (kind)
            k_add_w:  result = rj_val + rk_val;
            k_sub_w:  result = rj_val - rk_val;
            k_slt:    result = {31'd0, $signed(rj_val) < $signed(rk_val)};
            k_sltu:   result = {31'd0, rj_val < rk_val};
            k_nor:    result = ~(rj_val | rk_val);
            k_and:    result = rj_val & rk_val;
            k_or:     result = rj_val | rk_val;
            k_xor:    result = rj_val ^ rk_val;
            k_slli_w: result = rj_val << w.fmt_3r.rk;
            k_srli_w: result = rj_val >> w.fmt_3r.rk;
            k_srai_w: result = $signed(rj_val) >>> w.fmt_3r.rk;
            k_addi_w: result = addr;
            k_ld_w:   result = model_dmem[addr[9:2]];
            k_st_w:   reg_we = 1'b0;
            k_jirl: begin
                result  = model_pc + 32'd4;
                next_pc = rj_val + offs16x;
            end
            k_b: begin
                reg_we  = 1'b0;
                next_pc = model_pc + offs26x;
            end
            k_bl: begin
                result  = model_pc + 32'd4;
                dest    = 5'd1;
                next_pc = model_pc + offs26x;
            end
            k_beq: begin
                reg_we = 1'b0;
                if (rj_val == rd_val) begin
                    next_pc = model_pc + offs16x;
                end
            end
            k_bne: begin
                reg_we = 1'b0;
                if (rj_val != rd_val) begin
                    next_pc = model_pc + offs16x;
                end
            end
            default: result = {w.fmt_1ri20.si20, 12'd0};
        endcase
        check_value("debug_wb_pc", debug_wb_pc, model_pc);
        check_value("inst_sram_addr", inst_sram_addr, model_pc);
        check_value("inst_sram_we", {31'd0, inst_sram_we}, 32'd0);
        check_value("inst_sram_wdata", inst_sram_wdata, 32'd0);
        check_value("debug_wb_rf_we", {28'd0, debug_wb_rf_we}, {28'd0, {4{reg_we}}});
        if (reg_we) begin
            check_value("debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum}, {27'd0, dest});
            check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, result);
        end
        check_value("data_sram_we", {31'd0, data_sram_we}, {31'd0, kind == k_st_w});
        if (kind == k_st_w) begin
            check_value("data_sram_addr", data_sram_addr, addr);
            check_value("data_sram_wdata", data_sram_wdata, rd_val);
            model_dmem[addr[9:2]] = rd_val;
        end
        if (reg_we && dest != 5'd0) begin
            model_regs[dest[2:0]] = result;
        end
        model_pc = next_pc;
    endtask

    // ####################
    // Test sequence

    initial begin
        reset = 1'b1;
        build_program();
        @(posedge clk);
        // Valid is defined from the second reset edge on.
        repeat (4) begin
            @(posedge clk);
            check_idle();
        end
        @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        check_value("debug_wb_pc", debug_wb_pc, reset_pc - 32'd4);
        check_idle();
        model_pc = reset_pc;
        repeat (run_cycles) begin
            @(posedge clk);
            commit_and_check();
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- rtl/la32_core.sv
`timescale 1ns/1ps

module la32_core #(
    parameter logic [31:0] reset_pc = 32'h1c000000
) (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic        valid;
    logic [31:0] pc;
    logic [31:0] seq_pc;
    logic [31:0] next_pc;
    logic        br_taken;
    logic [31:0] br_target;
    logic        rj_eq_rd;

    logic [la32_pkg::alu_op_width-1:0] alu_op;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic [31:0] imm;
    logic [31:0] br_offs;
    logic        res_from_mem;
    logic        gr_we;
    logic        mem_we;
    logic [4:0]  dest;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic        is_beq;
    logic        is_bne;
    logic        is_jirl;
    logic        is_jump;

    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic        rf_we;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic [31:0] final_result;

    // ####################
    // Fetch

    // PC sits one word early in reset so the first fetch lands on reset_pc.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            pc    <= reset_pc - 32'd4;
        end else begin
            valid <= 1'b1;
            pc    <= next_pc;
        end
    end

    assign seq_pc  = pc + 32'd4;
    assign next_pc = br_taken ? br_target : seq_pc;

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = 32'd0;

    // ####################
    // Decode and execute

    la32_decode i_la32_decode (
        .inst         (inst_sram_rdata),
        .alu_op       (alu_op),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .imm          (imm),
        .br_offs      (br_offs),
        .res_from_mem (res_from_mem),
        .gr_we        (gr_we),
        .mem_we       (mem_we),
        .dest         (dest),
        .rf_raddr1    (rf_raddr1),
        .rf_raddr2    (rf_raddr2),
        .is_beq       (is_beq),
        .is_bne       (is_bne),
        .is_jirl      (is_jirl),
        .is_jump      (is_jump)
    );

    la32_regfile i_la32_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .rdata1 (rj_value),
        .raddr2 (rf_raddr2),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (final_result)
    );

    assign rj_eq_rd  = rj_value == rkd_value;
    assign br_taken  = ((is_beq & rj_eq_rd) | (is_bne & ~rj_eq_rd) | is_jump) & valid;
    assign br_target = is_jirl ? rj_value + br_offs : pc + br_offs;

    assign alu_src1 = src1_is_pc ? pc : rj_value;
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

    la32_alu i_la32_alu (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    // ####################
    // Memory and write-back

    assign data_sram_we    = mem_we & valid;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rkd_value;

    assign final_result = res_from_mem ? data_sram_rdata : alu_result;
    assign rf_we        = gr_we & valid;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = final_result;

    // A store never writes the register file.
    a_store_no_reg_write: assert property (
        @(posedge clk) data_sram_we |-> !rf_we
    ) else $error("Store also writes the register file");

endmodule

//--- rtl/la32_alu.sv
`timescale 1ns/1ps

module la32_alu (
    input  logic [la32_pkg::alu_op_width-1:0] alu_op,
    input  logic [31:0]                       alu_src1,
    input  logic [31:0]                       alu_src2,
    output logic [31:0]                       alu_result
);

    logic        use_sub;
    logic [31:0] adder_b;
    logic        adder_cin;
    logic [31:0] adder_sum;
    logic        adder_cout;

    logic [31:0] add_sub_result;
    logic [31:0] slt_result;
    logic [31:0] sltu_result;
    logic [31:0] and_result;
    logic [31:0] nor_result;
    logic [31:0] or_result;
    logic [31:0] xor_result;
    logic [31:0] sll_result;
    logic [31:0] srl_result;
    logic [31:0] sra_result;
    logic [31:0] lui_result;

    // Shared adder, subtract by inverting and carrying in.
    assign use_sub = alu_op[la32_pkg::alu_sub] | alu_op[la32_pkg::alu_slt]
                   | alu_op[la32_pkg::alu_sltu];
    assign adder_b   = use_sub ? ~alu_src2 : alu_src2;
    assign adder_cin = use_sub;
    assign {adder_cout, adder_sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {32'd0, adder_cin};

    assign add_sub_result = adder_sum;

    // Signs differ, or signs match and the difference is negative.
    assign slt_result = {31'd0, (alu_src1[31] & ~alu_src2[31])
                              | (~(alu_src1[31] ^ alu_src2[31]) & adder_sum[31])};
    // No borrow out means src1 >= src2.
    assign sltu_result = {31'd0, ~adder_cout};

    assign and_result = alu_src1 & alu_src2;
    assign nor_result = ~(alu_src1 | alu_src2);
    assign or_result  = alu_src1 | alu_src2;
    assign xor_result = alu_src1 ^ alu_src2;

    assign sll_result = alu_src1 << alu_src2[4:0];
    assign srl_result = alu_src1 >> alu_src2[4:0];
    assign sra_result = $signed(alu_src1) >>> alu_src2[4:0];
    assign lui_result = alu_src2;

    assign alu_result = ({32{alu_op[la32_pkg::alu_add] | alu_op[la32_pkg::alu_sub]}}
                            & add_sub_result)
                      | ({32{alu_op[la32_pkg::alu_slt]}}  & slt_result)
                      | ({32{alu_op[la32_pkg::alu_sltu]}} & sltu_result)
                      | ({32{alu_op[la32_pkg::alu_and]}}  & and_result)
                      | ({32{alu_op[la32_pkg::alu_nor]}}  & nor_result)
                      | ({32{alu_op[la32_pkg::alu_or]}}   & or_result)
                      | ({32{alu_op[la32_pkg::alu_xor]}}  & xor_result)
                      | ({32{alu_op[la32_pkg::alu_sll]}}  & sll_result)
                      | ({32{alu_op[la32_pkg::alu_srl]}}  & srl_result)
                      | ({32{alu_op[la32_pkg::alu_sra]}}  & sra_result)
                      | ({32{alu_op[la32_pkg::alu_lui]}}  & lui_result);

    always_comb begin
        assert final ($onehot0(alu_op))
            else $error("ALU op not one-hot: %b", alu_op);
    end

endmodule

//--- rtl/la32_regfile.sv
`timescale 1ns/1ps

module la32_regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero on read.
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

//--- rtl/la32_decode.sv
`timescale 1ns/1ps

module la32_decode (
    input  logic [31:0]                       inst,
    output logic [la32_pkg::alu_op_width-1:0] alu_op,
    output logic                              src1_is_pc,
    output logic                              src2_is_imm,
    output logic [31:0]                       imm,
    output logic [31:0]                       br_offs,
    output logic                              res_from_mem,
    output logic                              gr_we,
    output logic                              mem_we,
    output logic [4:0]                        dest,
    output logic [4:0]                        rf_raddr1,
    output logic [4:0]                        rf_raddr2,
    output logic                              is_beq,
    output logic                              is_bne,
    output logic                              is_jirl,
    output logic                              is_jump
);

    la32_pkg::la32_inst_t ins;

    logic inst_add_w;
    logic inst_sub_w;
    logic inst_slt;
    logic inst_sltu;
    logic inst_nor;
    logic inst_and;
    logic inst_or;
    logic inst_xor;
    logic inst_slli_w;
    logic inst_srli_w;
    logic inst_srai_w;
    logic inst_addi_w;
    logic inst_ld_w;
    logic inst_st_w;
    logic inst_jirl;
    logic inst_b;
    logic inst_bl;
    logic inst_beq;
    logic inst_bne;
    logic inst_lu12i_w;

    logic need_ui5;
    logic need_si20;
    logic need_si26;
    logic src2_is_4;
    logic src_reg_is_rd;

    assign ins = inst;

    // Opcode match per format view.
    assign inst_add_w   = ins.fmt_3r.opcode == la32_pkg::op_add_w;
    assign inst_sub_w   = ins.fmt_3r.opcode == la32_pkg::op_sub_w;
    assign inst_slt     = ins.fmt_3r.opcode == la32_pkg::op_slt;
    assign inst_sltu    = ins.fmt_3r.opcode == la32_pkg::op_sltu;
    assign inst_nor     = ins.fmt_3r.opcode == la32_pkg::op_nor;
    assign inst_and     = ins.fmt_3r.opcode == la32_pkg::op_and;
    assign inst_or      = ins.fmt_3r.opcode == la32_pkg::op_or;
    assign inst_xor     = ins.fmt_3r.opcode == la32_pkg::op_xor;
    assign inst_slli_w  = ins.fmt_3r.opcode == la32_pkg::op_slli_w;
    assign inst_srli_w  = ins.fmt_3r.opcode == la32_pkg::op_srli_w;
    assign inst_srai_w  = ins.fmt_3r.opcode == la32_pkg::op_srai_w;
    assign inst_addi_w  = ins.fmt_2ri12.opcode == la32_pkg::op_addi_w;
    assign inst_ld_w    = ins.fmt_2ri12.opcode == la32_pkg::op_ld_w;
    assign inst_st_w    = ins.fmt_2ri12.opcode == la32_pkg::op_st_w;
    assign inst_jirl    = ins.fmt_2ri16.opcode == la32_pkg::op_jirl;
    assign inst_beq     = ins.fmt_2ri16.opcode == la32_pkg::op_beq;
    assign inst_bne     = ins.fmt_2ri16.opcode == la32_pkg::op_bne;
    assign inst_b       = ins.fmt_i26.opcode == la32_pkg::op_b;
    assign inst_bl      = ins.fmt_i26.opcode == la32_pkg::op_bl;
    assign inst_lu12i_w = ins.fmt_1ri20.opcode == la32_pkg::op_lu12i_w;

    // Address calc and link values all go through the adder.
    assign alu_op[la32_pkg::alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                      | inst_jirl | inst_bl;
    assign alu_op[la32_pkg::alu_sub]  = inst_sub_w;
    assign alu_op[la32_pkg::alu_slt]  = inst_slt;
    assign alu_op[la32_pkg::alu_sltu] = inst_sltu;
    assign alu_op[la32_pkg::alu_and]  = inst_and;
    assign alu_op[la32_pkg::alu_nor]  = inst_nor;
    assign alu_op[la32_pkg::alu_or]   = inst_or;
    assign alu_op[la32_pkg::alu_xor]  = inst_xor;
    assign alu_op[la32_pkg::alu_sll]  = inst_slli_w;
    assign alu_op[la32_pkg::alu_srl]  = inst_srli_w;
    assign alu_op[la32_pkg::alu_sra]  = inst_srai_w;
    assign alu_op[la32_pkg::alu_lui]  = inst_lu12i_w;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b | inst_bl;
    assign src2_is_4 = inst_jirl | inst_bl;

    assign imm = src2_is_4 ? 32'd4 :
                 need_si20 ? {ins.fmt_1ri20.si20, 12'b0} :
                 need_ui5  ? {27'b0, ins.fmt_3r.rk} :
                             {{20{ins.fmt_2ri12.si12[11]}}, ins.fmt_2ri12.si12};

    assign br_offs = need_si26 ?
        {{4{ins.fmt_i26.offs_hi[9]}}, ins.fmt_i26.offs_hi, ins.fmt_i26.offs_lo, 2'b0} :
        {{14{ins.fmt_2ri16.offs16[15]}}, ins.fmt_2ri16.offs16, 2'b0};

    assign src_reg_is_rd = inst_beq | inst_bne | inst_st_w;

    assign src1_is_pc   = inst_jirl | inst_bl | inst_b;
    assign src2_is_imm  = need_ui5 | inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w
                        | inst_jirl | inst_bl | inst_b;
    assign res_from_mem = inst_ld_w;
    assign gr_we        = ~inst_st_w & ~inst_beq & ~inst_bne & ~inst_b;
    assign mem_we       = inst_st_w;
    assign dest         = inst_bl ? 5'd1 : ins.fmt_3r.rd;

    assign rf_raddr1 = ins.fmt_3r.rj;
    assign rf_raddr2 = src_reg_is_rd ? ins.fmt_3r.rd : ins.fmt_3r.rk;

    assign is_beq  = inst_beq;
    assign is_bne  = inst_bne;
    assign is_jirl = inst_jirl;
    assign is_jump = inst_jirl | inst_b | inst_bl;

    // Opcode constants must not overlap across formats.
    always_comb begin
        assert final ($onehot0({inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor,
                                inst_and, inst_or, inst_xor, inst_slli_w, inst_srli_w,
                                inst_srai_w, inst_addi_w, inst_ld_w, inst_st_w, inst_jirl,
                                inst_b, inst_bl, inst_beq, inst_bne, inst_lu12i_w}))
            else $error("Several instructions match word %h", inst);
    end

endmodule

//--- rtl/la32_pkg.sv
package la32_pkg;

    // One instruction word, read through each encoding format.
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_3r;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] si12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_2ri12;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_2ri16;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] si20;
            logic [4:0]  rd;
        } fmt_1ri20;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } fmt_i26;
    } la32_inst_t;

    // One-hot ALU operation bits.
    localparam int alu_op_width = 12;
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // 3R format, inst[31:15].
    localparam logic [16:0] op_add_w  = 17'h00020;
    localparam logic [16:0] op_sub_w  = 17'h00022;
    localparam logic [16:0] op_slt    = 17'h00024;
    localparam logic [16:0] op_sltu   = 17'h00025;
    localparam logic [16:0] op_nor    = 17'h00028;
    localparam logic [16:0] op_and    = 17'h00029;
    localparam logic [16:0] op_or     = 17'h0002a;
    localparam logic [16:0] op_xor    = 17'h0002b;
    localparam logic [16:0] op_slli_w = 17'h00081;
    localparam logic [16:0] op_srli_w = 17'h00089;
    localparam logic [16:0] op_srai_w = 17'h00091;

    // 2RI12 format, inst[31:22].
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    // 2RI16 and I26 formats, inst[31:26].
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;

    // 1RI20 format, inst[31:25].
    localparam logic [6:0] op_lu12i_w = 7'h0a;

endpackage
